/* loong_tlb.f */
+incdir+testbench
logic/tlb_pkg.sv
logic/tlb_write_ctrl.sv
logic/tlb_entry.sv
logic/tlb_lookup.sv
logic/loong_tlb.sv
testbench/tb_loong_tlb.sv

/* Makefile */
SRCS = loong_tlb.f $(wildcard logic/*.sv) $(wildcard testbench/*.sv testbench/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vtb_loong_tlb: $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_loong_tlb -f loong_tlb.f

run: obj_dir/Vtb_loong_tlb
	./obj_dir/Vtb_loong_tlb | tee /dev/stderr | grep -F '** PASS **' > /dev/null

clean:
	rm -rf obj_dir

/* testbench/tlb_ref_model.svh */
`ifndef TLB_REF_MODEL_SVH
`define TLB_REF_MODEL_SVH

// uses TLBNUM and IDX_W of the including module
tlb_pkg::tlb_entry_t model_tlb [TLBNUM];

function automatic void model_reset();
    for (int i = 0; i < TLBNUM; i++) begin
        model_tlb[i] = '0;
    end
endfunction

function automatic void model_write(input logic [IDX_W-1:0] idx, input tlb_pkg::tlb_entry_t ent);
    model_tlb[idx] = ent;
endfunction

function automatic tlb_pkg::tlb_entry_t model_read(input logic [IDX_W-1:0] idx);
    return model_tlb[idx];
endfunction

// 4M pages compare vppn[18:10] only
function automatic logic model_vppn_eq(input tlb_pkg::tlb_entry_t ent, input logic [18:0] vppn);
    if (ent.ps == tlb_pkg::PS_4M) begin
        return ent.vppn[18:10] == vppn[18:10];
    end
    return ent.vppn == vppn;
endfunction

function automatic void model_search(
    input  tlb_pkg::tlb_search_req_t req,
    output tlb_pkg::tlb_search_rsp_t rsp,
    output logic [IDX_W-1:0]         idx
);
    tlb_pkg::tlb_entry_t ent;
    logic                odd;
    rsp = '0;
    idx = '0;
    for (int i = 0; i < TLBNUM; i++) begin
        ent = model_tlb[i];
        if (ent.e && (ent.g || ent.asid == req.asid) && model_vppn_eq(ent, req.vppn)) begin
            odd       = (ent.ps == tlb_pkg::PS_4M) ? req.vppn[9] : req.va_bit12;
            rsp.found = 1'b1;
            rsp.ps    = ent.ps;
            rsp.page  = odd ? ent.page1 : ent.page0;
            idx       = IDX_W'(i);
        end
    end
endfunction

function automatic void model_invalidate(input logic [4:0] op, input tlb_pkg::tlb_search_req_t key);
    tlb_pkg::tlb_entry_t ent;
    logic                asid_eq;
    logic                va_eq;
    logic                hit;
    for (int i = 0; i < TLBNUM; i++) begin
        ent     = model_tlb[i];
        asid_eq = (ent.asid == key.asid);
        va_eq   = model_vppn_eq(ent, key.vppn);
        case (op)
            5'd0, 5'd1: hit = 1'b1;
            5'd2:       hit = ent.g;
            5'd3:       hit = !ent.g;
            5'd4:       hit = !ent.g && asid_eq;
            5'd5:       hit = !ent.g && asid_eq && va_eq;
            5'd6:       hit = (ent.g || asid_eq) && va_eq;
            default:    hit = 1'b0;
        endcase
        if (hit) begin
            model_tlb[i].e = 1'b0;
        end
    end
endfunction

`endif

/* testbench/tb_loong_tlb.sv */
`timescale 1ns/1ns

module tb_loong_tlb;

    localparam int TLBNUM = 16;
    localparam int IDX_W  = $clog2(TLBNUM);
    localparam int N_IDLE = 20;
    localparam int N_S0   = 200;
    localparam int N_DUAL = 100;
    localparam int N_OPS  = 9;
    localparam int N_WS   = 20;
    // cycles of reset plus all tests
    localparam int RUN_CYCLES = 3 + N_IDLE + TLBNUM + 2 * TLBNUM + N_S0 + N_DUAL
                              + N_OPS * (2 * TLBNUM + 1) + 2 * N_WS;
    localparam int MAX_CYCLES = 2 * RUN_CYCLES;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     we;
    logic                     invtlb_valid;
    tlb_pkg::tlb_inv_op_e     invtlb_op;
    logic [IDX_W-1:0]         w_index;
    tlb_pkg::tlb_entry_t      w_entry;
    logic [IDX_W-1:0]         r_index;
    tlb_pkg::tlb_entry_t      r_entry;
    tlb_pkg::tlb_search_req_t s0_req;
    tlb_pkg::tlb_search_req_t s1_req;
    tlb_pkg::tlb_search_rsp_t s0_rsp;
    tlb_pkg::tlb_search_rsp_t s1_rsp;
    logic [IDX_W-1:0]         s0_index;
    logic [IDX_W-1:0]         s1_index;

    int          cycles      = 0;
    int          checks      = 0;
    int          errors      = 0;
    int          test_errors = 0;
    int          tests       = 0;
    logic [15:0] lfsr        = 16'd99;

    `include "tlb_ref_model.svh"

    loong_tlb #(
        .TLBNUM       (TLBNUM      )
    ) DUT (
        .clk          (clk         ),
        .rst_n        (rst_n       ),
        .s0_req       (s0_req      ),
        .s0_rsp       (s0_rsp      ),
        .s0_index     (s0_index    ),
        .s1_req       (s1_req      ),
        .s1_rsp       (s1_rsp      ),
        .s1_index     (s1_index    ),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op   ),
        .we           (we          ),
        .w_index      (w_index     ),
        .w_entry      (w_entry     ),
        .r_index      (r_index     ),
        .r_entry      (r_entry     )
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // index sits in vppn[13:10], so a key matches one entry at most
    function automatic tlb_pkg::tlb_entry_t rand_entry(input logic [IDX_W-1:0] idx);
        tlb_pkg::tlb_entry_t ent;
        ent.e              = 1'b1;
        ent.vppn           = 19'(rand_bits(19));
        ent.vppn[10+:IDX_W] = idx;
        ent.ps             = rand_bits(1) ? tlb_pkg::PS_4M : tlb_pkg::PS_4K;
        ent.asid           = 10'(rand_bits(10));
        ent.g              = (rand_bits(2) == 0);
        ent.page0          = 26'(rand_bits(26));
        ent.page1          = 26'(rand_bits(26));
        return ent;
    endfunction

    function automatic tlb_pkg::tlb_search_req_t key_for(input tlb_pkg::tlb_entry_t ent);
        tlb_pkg::tlb_search_req_t k;
        k.vppn     = 19'(rand_bits(19));
        k.va_bit12 = 1'(rand_bits(1));
        k.asid     = ent.g ? 10'(rand_bits(10)) : ent.asid;
        if (ent.ps == tlb_pkg::PS_4M) begin
            k.vppn[18:10] = ent.vppn[18:10];
        end else begin
            k.vppn = ent.vppn;
        end
        return k;
    endfunction

    function automatic tlb_pkg::tlb_search_req_t make_key();
        tlb_pkg::tlb_search_req_t k;
        logic [IDX_W-1:0]         idx;
        logic [1:0]               sel;
        sel = 2'(rand_bits(2));
        idx = IDX_W'(rand_bits(IDX_W));
        k   = key_for(model_read(idx));
        // a quarter fully random, a quarter with a foreign asid
        if (sel == 2'd0) begin
            k.vppn = 19'(rand_bits(19));
        end else if (sel == 2'd1) begin
            k.asid = 10'(rand_bits(10));
        end
        return k;
    endfunction

    task automatic check_rsp(input string name, input tlb_pkg::tlb_search_rsp_t got,
                             input logic [IDX_W-1:0] got_idx,
                             input tlb_pkg::tlb_search_rsp_t exp,
                             input logic [IDX_W-1:0] exp_idx);
        checks++;
        if (got !== exp || got_idx !== exp_idx) begin
            test_errors++;
            $display("** Error %s_rsp/%s_index: got %h/%h, expected %h/%h",
                     name, name, got, got_idx, exp, exp_idx);
        end
    endtask

    task automatic check_entry(input string name, input tlb_pkg::tlb_entry_t got,
                               input tlb_pkg::tlb_entry_t exp);
        checks++;
        if (got !== exp) begin
            test_errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            test_errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
        we           = 1'b0;
        invtlb_valid = 1'b0;
    endtask

    task automatic write_entry(input logic [IDX_W-1:0] idx, input tlb_pkg::tlb_entry_t ent);
        next_cycle();
        we      = 1'b1;
        w_index = idx;
        w_entry = ent;
        model_write(idx, ent);
    endtask

    task automatic read_check(input logic [IDX_W-1:0] idx);
        next_cycle();
        r_index = idx;
        @(negedge clk);
        check_entry("r_entry", r_entry, model_read(idx));
    endtask

    task automatic search_check(input tlb_pkg::tlb_search_req_t k0,
                                input tlb_pkg::tlb_search_req_t k1);
        tlb_pkg::tlb_search_rsp_t rsp;
        logic [IDX_W-1:0]         idx;
        next_cycle();
        s0_req = k0;
        s1_req = k1;
        @(negedge clk);
        model_search(k0, rsp, idx);
        check_rsp("s0", s0_rsp, s0_index, rsp, idx);
        model_search(k1, rsp, idx);
        check_rsp("s1", s1_rsp, s1_index, rsp, idx);
    endtask

    task automatic invalidate(input logic [4:0] op, input tlb_pkg::tlb_search_req_t key);
        next_cycle();
        s1_req       = key;
        invtlb_valid = 1'b1;
        invtlb_op    = tlb_pkg::tlb_inv_op_e'(op);
        model_invalidate(op, key);
    endtask

    task automatic end_test(input string name);
        $display("%-26s %s (%0d errors)", name,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
        errors      += test_errors;
        test_errors = 0;
        tests++;
    endtask

    initial begin
        tlb_pkg::tlb_entry_t ent;
        logic [IDX_W-1:0]    idx;
        logic [4:0]          op;
        rst_n        = 1'b0;
        we           = 1'b0;
        invtlb_valid = 1'b0;
        invtlb_op    = tlb_pkg::clear_all0;
        w_index      = '0;
        w_entry      = '0;
        r_index      = '0;
        s0_req       = '0;
        s1_req       = '0;
        model_reset();
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int n = 0; n < N_IDLE; n++) begin
            search_check(make_key(), make_key());
        end
        for (int i = 0; i < TLBNUM; i++) begin
            next_cycle();
            r_index = IDX_W'(i);
            @(negedge clk);
            ent = model_read(IDX_W'(i));
            check_bit("r_entry.e", r_entry.e, ent.e);
        end
        end_test("reset state");

        for (int i = 0; i < TLBNUM; i++) begin
            write_entry(IDX_W'(i), rand_entry(IDX_W'(i)));
        end
        for (int i = 0; i < TLBNUM; i++) begin
            read_check(IDX_W'(i));
        end
        end_test("write then read");

        for (int n = 0; n < N_S0; n++) begin
            search_check(make_key(), '0);
        end
        end_test("port 0 search");

        for (int n = 0; n < N_DUAL; n++) begin
            search_check(make_key(), make_key());
        end
        end_test("dual port search");

        // ops 0..6, then two undefined codes
        for (int n = 0; n < N_OPS; n++) begin
            op = (n < 7) ? 5'(n) : ((n == 7) ? 5'd7 : 5'd31);
            for (int i = 0; i < TLBNUM; i++) begin
                write_entry(IDX_W'(i), rand_entry(IDX_W'(i)));
            end
            invalidate(op, make_key());
            for (int i = 0; i < TLBNUM; i++) begin
                read_check(IDX_W'(i));
            end
        end
        end_test("invalidate ops");

        for (int n = 0; n < N_WS; n++) begin
            idx = IDX_W'(rand_bits(IDX_W));
            ent = rand_entry(idx);
            write_entry(idx, ent);
            search_check(key_for(ent), make_key());
        end
        end_test("write then search");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* logic/loong_tlb.sv */
`timescale 1ns/1ns

module loong_tlb #(
    parameter int TLBNUM = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // search port 0 (fetch)
    input  tlb_pkg::tlb_search_req_t  s0_req,
    output tlb_pkg::tlb_search_rsp_t  s0_rsp,
    output logic [$clog2(TLBNUM)-1:0] s0_index,
    // search port 1 (load/store)
    input  tlb_pkg::tlb_search_req_t  s1_req,
    output tlb_pkg::tlb_search_rsp_t  s1_rsp,
    output logic [$clog2(TLBNUM)-1:0] s1_index,
    // invtlb
    input  logic                      invtlb_valid,
    input  tlb_pkg::tlb_inv_op_e      invtlb_op,
    // write port
    input  logic                      we,
    input  logic [$clog2(TLBNUM)-1:0] w_index,
    input  tlb_pkg::tlb_entry_t       w_entry,
    // read port
    input  logic [$clog2(TLBNUM)-1:0] r_index,
    output tlb_pkg::tlb_entry_t       r_entry
);

    logic [TLBNUM-1:0]      wen;
    tlb_pkg::tlb_inv_mode_t inv_mode;
    logic [TLBNUM-1:0]      m0;
    logic [TLBNUM-1:0]      m1;
    tlb_pkg::tlb_entry_t    entries [TLBNUM];

    tlb_write_ctrl #(
        .TLBNUM         (TLBNUM         )
    ) u_write_ctrl (
        .clk            (clk            ),
        .rst_n          (rst_n          ),
        .we             (we             ),
        .w_index        (w_index        ),
        .w_entry        (w_entry        ),
        .invtlb_valid   (invtlb_valid   ),
        .invtlb_op      (invtlb_op      ),
        .wen            (wen            ),
        .inv_mode       (inv_mode       )
    );

    // entry array
    for (genvar i = 0; i < TLBNUM; i++) begin : g_entry
        tlb_entry u_entry (
            .clk        (clk            ),
            .rst_n      (rst_n          ),
            .wen        (wen[i]         ),
            .w_entry    (w_entry        ),
            .inv_mode   (inv_mode       ),
            .s0_req     (s0_req         ),
            .s1_req     (s1_req         ),
            .match0     (m0[i]          ),
            .match1     (m1[i]          ),
            .entry      (entries[i]     )
        );
    end

    tlb_lookup #(
        .TLBNUM         (TLBNUM         )
    ) u_lookup (
        .clk            (clk            ),
        .rst_n          (rst_n          ),
        .m0             (m0             ),
        .m1             (m1             ),
        .entries        (entries        ),
        .s0_req         (s0_req         ),
        .s1_req         (s1_req         ),
        .r_index        (r_index        ),
        .s0_rsp         (s0_rsp         ),
        .s0_index       (s0_index       ),
        .s1_rsp         (s1_rsp         ),
        .s1_index       (s1_index       ),
        .r_entry        (r_entry        )
    );

endmodule

/* logic/tlb_lookup.sv */
`timescale 1ns/1ns

module tlb_lookup #(
    parameter int TLBNUM = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [TLBNUM-1:0]         m0,
    input  logic [TLBNUM-1:0]         m1,
    input  tlb_pkg::tlb_entry_t       entries [TLBNUM],
    input  tlb_pkg::tlb_search_req_t  s0_req,
    input  tlb_pkg::tlb_search_req_t  s1_req,
    input  logic [$clog2(TLBNUM)-1:0] r_index,
    output tlb_pkg::tlb_search_rsp_t  s0_rsp,
    output logic [$clog2(TLBNUM)-1:0] s0_index,
    output tlb_pkg::tlb_search_rsp_t  s1_rsp,
    output logic [$clog2(TLBNUM)-1:0] s1_index,
    output tlb_pkg::tlb_entry_t       r_entry
);

    localparam int IDX_W = $clog2(TLBNUM);

    // or-encode, valid since at most one bit is set
    function automatic logic [IDX_W-1:0] hit_index(input logic [TLBNUM-1:0] m);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < TLBNUM; i++) begin
            if (m[i]) begin
                idx = idx | IDX_W'(i);
            end
        end
        return idx;
    endfunction

    function automatic tlb_pkg::tlb_search_rsp_t hit_rsp(
        input logic                     found,
        input tlb_pkg::tlb_search_req_t req,
        input tlb_pkg::tlb_entry_t      ent
    );
        tlb_pkg::tlb_search_rsp_t rsp;
        logic                     odd;
        rsp = '0;
        odd = (ent.ps == tlb_pkg::PS_4M) ? req.vppn[tlb_pkg::VPPN_HI_LSB-1] : req.va_bit12;
        if (found) begin
            rsp.found = 1'b1;
            rsp.ps    = ent.ps;
            rsp.page  = odd ? ent.page1 : ent.page0;
        end
        return rsp;
    endfunction

    logic [IDX_W-1:0] idx0;
    logic [IDX_W-1:0] idx1;

    assign idx0 = hit_index(m0);
    assign idx1 = hit_index(m1);

    // fetch port
    assign s0_index = idx0;
    assign s0_rsp   = hit_rsp(|m0, s0_req, entries[idx0]);

    // load/store port
    assign s1_index = idx1;
    assign s1_rsp   = hit_rsp(|m1, s1_req, entries[idx1]);

    assign r_entry = entries[r_index];

    a_m0_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(m0));
    a_m1_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(m1));

endmodule

/* logic/tlb_entry.sv */
`timescale 1ns/1ns

module tlb_entry (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wen,
    input  tlb_pkg::tlb_entry_t       w_entry,
    input  tlb_pkg::tlb_inv_mode_t    inv_mode,
    input  tlb_pkg::tlb_search_req_t  s0_req,
    input  tlb_pkg::tlb_search_req_t  s1_req,
    output logic                      match0,
    output logic                      match1,
    output tlb_pkg::tlb_entry_t       entry
);

    logic                e_q;
    tlb_pkg::tlb_entry_t data_q;
    logic                is_4m;
    logic                s0_asid_ok;
    logic                s1_asid_eq;
    logic                s1_vppn_eq;
    logic                g_ok;
    logic                asid_ok;
    logic                va_ok;
    logic                inv_hit;

    // 4M pages ignore the low vppn bits
    function automatic logic vppn_hit(
        input logic [tlb_pkg::VPPN_W-1:0] key,
        input logic [tlb_pkg::VPPN_W-1:0] tag,
        input logic                       huge
    );
        logic hi_eq;
        logic lo_eq;
        hi_eq = key[tlb_pkg::VPPN_W-1:tlb_pkg::VPPN_HI_LSB]
             == tag[tlb_pkg::VPPN_W-1:tlb_pkg::VPPN_HI_LSB];
        lo_eq = key[tlb_pkg::VPPN_HI_LSB-1:0] == tag[tlb_pkg::VPPN_HI_LSB-1:0];
        return hi_eq && (huge || lo_eq);
    endfunction

    assign is_4m = (data_q.ps == tlb_pkg::PS_4M);

    // search compares
    assign s0_asid_ok = data_q.g || (data_q.asid == s0_req.asid);
    assign s1_asid_eq = (data_q.asid == s1_req.asid);
    assign s1_vppn_eq = vppn_hit(s1_req.vppn, data_q.vppn, is_4m);

    assign match0 = e_q && s0_asid_ok && vppn_hit(s0_req.vppn, data_q.vppn, is_4m);
    assign match1 = e_q && (data_q.g || s1_asid_eq) && s1_vppn_eq;

    // invtlb conditions, keys come from search port 1
    assign g_ok    = (!inv_mode.need_g1 || data_q.g) && (!inv_mode.need_g0 || !data_q.g);
    assign asid_ok = !inv_mode.chk_asid || s1_asid_eq || (inv_mode.or_global && data_q.g);
    assign va_ok   = !inv_mode.chk_va || s1_vppn_eq;
    assign inv_hit = inv_mode.inv && g_ok && asid_ok && va_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_q <= 1'b0;
        end else if (wen) begin
            e_q <= w_entry.e;
        end else if (inv_hit) begin
            e_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            data_q <= w_entry;
        end
    end

    always_comb begin
        entry   = data_q;
        entry.e = e_q;
    end

endmodule

/* logic/tlb_write_ctrl.sv */
`timescale 1ns/1ns

module tlb_write_ctrl #(
    parameter int TLBNUM = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    we,
    input  logic [$clog2(TLBNUM)-1:0] w_index,
    input  tlb_pkg::tlb_entry_t     w_entry,
    input  logic                    invtlb_valid,
    input  tlb_pkg::tlb_inv_op_e    invtlb_op,
    output logic [TLBNUM-1:0]       wen,
    output tlb_pkg::tlb_inv_mode_t  inv_mode
);

    // one-hot write enable
    always_comb begin
        wen = '0;
        if (we) begin
            wen[w_index] = 1'b1;
        end
    end

    always_comb begin
        inv_mode = '0;
        case (invtlb_op)
            tlb_pkg::clear_all0,
            tlb_pkg::clear_all1: begin
                inv_mode.inv = invtlb_valid;
            end
            tlb_pkg::clear_global: begin
                inv_mode.inv     = invtlb_valid;
                inv_mode.need_g1 = 1'b1;
            end
            tlb_pkg::clear_private: begin
                inv_mode.inv     = invtlb_valid;
                inv_mode.need_g0 = 1'b1;
            end
            tlb_pkg::clear_asid: begin
                inv_mode.inv      = invtlb_valid;
                inv_mode.need_g0  = 1'b1;
                inv_mode.chk_asid = 1'b1;
            end
            tlb_pkg::clear_asid_va: begin
                inv_mode.inv      = invtlb_valid;
                inv_mode.need_g0  = 1'b1;
                inv_mode.chk_asid = 1'b1;
                inv_mode.chk_va   = 1'b1;
            end
            tlb_pkg::clear_asid_or_global_va: begin
                // global entries skip the asid check
                inv_mode.inv       = invtlb_valid;
                inv_mode.chk_asid  = 1'b1;
                inv_mode.chk_va    = 1'b1;
                inv_mode.or_global = 1'b1;
            end
            default: begin
                inv_mode = '0;
            end
        endcase
    end

    a_no_write_and_inv: assert property (@(posedge clk) disable iff (!rst_n)
        !(we && invtlb_valid));

    // only 4K and 4M pages are supported by the compare logic
    a_write_ps_legal: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> (w_entry.ps == tlb_pkg::PS_4K || w_entry.ps == tlb_pkg::PS_4M));

endmodule

/* logic/tlb_pkg.sv */
package tlb_pkg;

    localparam int VPPN_W = 19;
    localparam int ASID_W = 10;
    localparam int PPN_W  = 20;
    localparam int PS_W   = 6;

    // page size codes as written into entry.ps
    localparam logic [PS_W-1:0] PS_4K = 6'd12;
    localparam logic [PS_W-1:0] PS_4M = 6'd21;

    // 4 MB entries compare vppn[18:10] only, odd page picked by vppn[9]
    localparam int VPPN_HI_LSB = 10;

    // one half of an even/odd page pair
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       plv;
        logic [1:0]       mat;
        logic             d;
        logic             v;
    } tlb_page_t;

    typedef struct packed {
        logic              e;
        logic [VPPN_W-1:0] vppn;
        logic [PS_W-1:0]   ps;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    typedef struct packed {
        logic [VPPN_W-1:0] vppn;
        logic              va_bit12;
        logic [ASID_W-1:0] asid;
    } tlb_search_req_t;

    // index travels on its own port, its width depends on TLBNUM
    typedef struct packed {
        logic            found;
        logic [PS_W-1:0] ps;
        tlb_page_t       page;
    } tlb_search_rsp_t;

    typedef enum logic [4:0] {
        clear_all0              = 5'd0,
        clear_all1              = 5'd1,
        clear_global            = 5'd2,
        clear_private           = 5'd3,
        clear_asid              = 5'd4,
        clear_asid_va           = 5'd5,
        clear_asid_or_global_va = 5'd6
    } tlb_inv_op_e;

    // decoded invtlb, applied by every entry against the s1 key
    typedef struct packed {
        logic inv;
        logic need_g1;
        logic need_g0;
        logic chk_asid;
        logic chk_va;
        logic or_global;
    } tlb_inv_mode_t;

endpackage
